// ==== include/regs_consts.svh ====
/* register map constants for the spi control block
   addresses, frame layout, reset values and 4094 chain timing */

`ifndef REGS_CONSTS_SVH
`define REGS_CONSTS_SVH

// frame layout, msb first: access flag, 7 bit address, 32 bit data
`define FRAME_BITS        40
`define REG_ADDR_BITS     7
`define REG_WORD_BITS     32

// register addresses
`define REG_LED           7'd7
`define REG_SPI_MUX       7'd8
`define REG_4094          7'd9     // mirrored onto the 4094 chain
`define REG_MODE          7'd12
`define REG_DIRECT        7'd14
`define REG_DIRECT2       7'd15

`define UNKNOWN_PATTERN   32'h000f_0f0f   // read data for unmapped address
`define LED_RESET         32'h00aa_aaaf   // handy test pattern on the leds

// clk cycles per sr_clk phase, one bit takes twice this
`define SR_HALF_PERIOD    2

`endif

// ==== design/regs_pkg.sv ====
/* shared types for the spi register block
   address and data word as carried between slave, bank and driver */

`default_nettype none

`include "regs_consts.svh"

package regs_pkg;

  // register address as decoded from frame bits 38..32
  typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;

  // one register word, also the data field of a frame
  typedef logic [`REG_WORD_BITS-1:0] reg_word_t;

endpackage

`default_nettype wire

// ==== design/spi_frame_slave.sv ====
/* spi frame slave, oversampled in the clk domain
   assembles 40 bit frames, strobes reads at bit 8 and writes at bit 40 */

`timescale 1ns/1ns
`default_nettype none

`include "regs_consts.svh"

module spi_frame_slave import regs_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      sclk,
  input  wire logic      cs_n,
  input  wire logic      sdi,
  input  wire reg_word_t rd_data,   // from bank, valid while rd_stb
  output logic           sdo,
  output logic           rd_stb,
  output logic           wr_stb,
  output reg_addr_t      rd_addr,
  output reg_addr_t      wr_addr,
  output reg_word_t      wr_data
);

  localparam int CNT_W    = $clog2(`FRAME_BITS + 1);
  localparam int HDR_BITS = `FRAME_BITS - `REG_WORD_BITS;   // flag plus address

  // [0],[1] synchronizer, [2] history for edge detect
  logic [2:0]            sclk_pipe;
  logic [2:0]            cs_pipe;
  logic [2:0]            sdi_pipe;
  logic                  sclk_fall;
  logic                  cs_idle;
  logic [`FRAME_BITS-1:0] shift_q;
  logic [`FRAME_BITS-1:0] shift_next;
  logic [CNT_W-1:0]      bit_cnt;
  reg_word_t             out_q;      // read data shifter

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_pipe <= '0;
      cs_pipe   <= '1;   // deselected
      sdi_pipe  <= '0;
    end
    else
    begin
      sclk_pipe <= {sclk_pipe[1:0], sclk};
      cs_pipe   <= {cs_pipe[1:0], cs_n};
      sdi_pipe  <= {sdi_pipe[1:0], sdi};
    end
  end

  assign sclk_fall  = sclk_pipe[2] & ~sclk_pipe[1];  // seen 3 clk after the pin
  assign cs_idle    = cs_pipe[2];                    // aligned with sclk history
  // sdi_pipe[2] still holds the bit from before the falling edge
  assign shift_next = {shift_q[`FRAME_BITS-2:0], sdi_pipe[2]};

  // bit counter, frame shifter and strobes
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      shift_q <= '0;
      rd_stb  <= 1'b0;
      wr_stb  <= 1'b0;
    end
    else
    begin
      rd_stb <= 1'b0;   // single cycle pulses
      wr_stb <= 1'b0;
      if (cs_idle)
      begin
        bit_cnt <= '0;   // early rise drops the frame
        shift_q <= '0;
      end
      else if (sclk_fall && bit_cnt != CNT_W'(`FRAME_BITS))
      begin
        shift_q <= shift_next;
        bit_cnt <= bit_cnt + 1'b1;
        rd_stb  <= (bit_cnt == CNT_W'(HDR_BITS - 1));   // address complete
        wr_stb  <= (bit_cnt == CNT_W'(`FRAME_BITS - 1))
                   && !shift_next[`FRAME_BITS-1];       // flag 0 is write
      end
    end
  end

  assign rd_addr = shift_q[`REG_ADDR_BITS-1:0];                // low byte after bit 8
  assign wr_addr = shift_q[`FRAME_BITS-2 -: `REG_ADDR_BITS];
  assign wr_data = shift_q[`REG_WORD_BITS-1:0];

  // read data goes out msb first, one bit per falling edge
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_q <= '0;
    else if (cs_idle)
      out_q <= '0;
    else if (rd_stb)
      out_q <= rd_data;   // bit 31 on sdo before next rising sclk
    else if (sclk_fall && bit_cnt >= CNT_W'(HDR_BITS) && bit_cnt != CNT_W'(`FRAME_BITS))
      out_q <= out_q << 1;
  end

  assign sdo = out_q[`REG_WORD_BITS-1];

  // strobes come 32 sclk periods apart, never together
  a_strobes_apart: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_stb && wr_stb));

  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    bit_cnt <= CNT_W'(`FRAME_BITS));

endmodule

`default_nettype wire

// ==== design/register_bank.sv ====
/* control register bank
   six registers written by frame strobes, read through a comb mux */

`timescale 1ns/1ns
`default_nettype none

`include "regs_consts.svh"

module register_bank import regs_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire reg_addr_t rd_addr,
  input  wire reg_addr_t wr_addr,
  input  wire logic      wr_stb,
  input  wire reg_word_t wr_data,
  output reg_word_t      rd_data,
  output reg_word_t      reg_led,
  output reg_word_t      reg_spi_mux,
  output reg_word_t      reg_4094,
  output reg_word_t      reg_mode,
  output reg_word_t      reg_direct,
  output reg_word_t      reg_direct2,
  output logic           load_4094     // new value in reg_4094 this cycle
);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reg_led     <= `LED_RESET;
      reg_spi_mux <= '0;           // no spi device selected
      reg_4094    <= '0;
      reg_mode    <= '0;
      reg_direct  <= '0;
      reg_direct2 <= '0;
      load_4094   <= 1'b0;
    end
    else
    begin
      load_4094 <= wr_stb && (wr_addr == `REG_4094);   // same edge as the update
      if (wr_stb)
      begin
        case (wr_addr)
          `REG_LED:     reg_led     <= wr_data;
          `REG_SPI_MUX: reg_spi_mux <= wr_data;
          `REG_4094:    reg_4094    <= wr_data;
          `REG_MODE:    reg_mode    <= wr_data;
          `REG_DIRECT:  reg_direct  <= wr_data;
          `REG_DIRECT2: reg_direct2 <= wr_data;
          default:      ;   // unmapped, write dropped
        endcase
      end
    end
  end

  // read mux, sampled by the slave while rd_stb is high
  always_comb
  begin
    case (rd_addr)
      `REG_LED:     rd_data = reg_led;
      `REG_SPI_MUX: rd_data = reg_spi_mux;
      `REG_4094:    rd_data = reg_4094;
      `REG_MODE:    rd_data = reg_mode;
      `REG_DIRECT:  rd_data = reg_direct;
      `REG_DIRECT2: rd_data = reg_direct2;
      default:      rd_data = `UNKNOWN_PATTERN;   // lets the host spot a bad address
    endcase
  end

  // chain reload follows a write strobe and sees the new word in reg_4094
  a_load_from_write: assert property (@(posedge clk) disable iff (!rst_n)
    load_4094 |-> $past(wr_stb) && (reg_4094 == $past(wr_data)));

endmodule

`default_nettype wire

// ==== design/hc4094_driver.sv ====
/* 74hc4094 chain driver
   shifts each new reg_4094 value out msb first, then pulses the latch strobe */

`timescale 1ns/1ns
`default_nettype none

`include "regs_consts.svh"

module hc4094_driver import regs_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      load_4094,
  input  wire reg_word_t reg_4094,
  output logic           sr_clk,
  output logic           sr_data,
  output logic           sr_strobe
);

  localparam int HALF_W = $clog2(`SR_HALF_PERIOD + 1);
  localparam int BIT_W  = $clog2(`REG_WORD_BITS + 1);

  typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_STROBE} drv_state_t;

  drv_state_t        state;
  logic [HALF_W-1:0] half_cnt;   // clk cycles within one sr_clk phase
  logic [BIT_W-1:0]  bits_left;
  logic              pending;    // load seen while busy
  logic              start;
  logic              half_done;
  logic              bit_done;
  reg_word_t         word_q;

  // restart after strobe picks up the newest reg_4094
  assign start     = (state == ST_IDLE && load_4094)
                     || (state == ST_STROBE && (pending || load_4094));
  assign half_done = (half_cnt == HALF_W'(`SR_HALF_PERIOD - 1));
  assign bit_done  = (state == ST_SHIFT) && half_done && sr_clk;   // end of high phase

  always_ff @(posedge clk)
  begin
    if (start)
      word_q <= reg_4094;
    else if (bit_done)
      word_q <= word_q << 1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= ST_IDLE;
      half_cnt  <= '0;
      bits_left <= '0;
      pending   <= 1'b0;
      sr_clk    <= 1'b0;
      sr_data   <= 1'b0;
      sr_strobe <= 1'b0;
    end
    else
    begin
      sr_strobe <= 1'b0;
      if (start)
      begin
        state     <= ST_SHIFT;
        half_cnt  <= '0;
        bits_left <= BIT_W'(`REG_WORD_BITS);
        pending   <= 1'b0;
        sr_clk    <= 1'b0;
        sr_data   <= reg_4094[`REG_WORD_BITS-1];   // msb set up while clock low
      end
      else
      begin
        case (state)
          ST_SHIFT:
          begin
            if (load_4094)
              pending <= 1'b1;
            if (half_done)
            begin
              half_cnt <= '0;
              sr_clk   <= ~sr_clk;   // chain samples on the rise
              if (sr_clk)
              begin
                bits_left <= bits_left - 1'b1;
                if (bits_left == BIT_W'(1))
                begin
                  state     <= ST_STROBE;
                  sr_strobe <= 1'b1;   // latch 129 clk after the load
                end
                else
                  sr_data <= word_q[`REG_WORD_BITS-2];
              end
            end
            else
              half_cnt <= half_cnt + 1'b1;
          end
          default: state <= ST_IDLE;   // strobe done, nothing pending
        endcase
      end
    end
  end

  // latch only once the whole word has been clocked in
  a_strobe_last: assert property (@(posedge clk) disable iff (!rst_n)
    sr_strobe |-> (bits_left == '0) && $past(sr_clk));

endmodule

`default_nettype wire

// ==== design/spi_ctl_top.sv ====
/* spi control block top
   frame slave feeding the register bank, bank feeding the 4094 driver */

`timescale 1ns/1ns
`default_nettype none

module spi_ctl_top import regs_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic sclk,
  input  wire logic cs_n,
  input  wire logic sdi,
  output logic      sdo,
  output reg_word_t reg_led,
  output reg_word_t reg_spi_mux,
  output reg_word_t reg_4094,
  output reg_word_t reg_mode,
  output reg_word_t reg_direct,
  output reg_word_t reg_direct2,
  output logic      sr_clk,
  output logic      sr_data,
  output logic      sr_strobe
);

  logic      rd_stb;
  logic      wr_stb;
  reg_addr_t rd_addr;
  reg_addr_t wr_addr;
  reg_word_t wr_data;
  reg_word_t rd_data;
  logic      load_4094;   // bank to driver reload pulse

  spi_frame_slave spi_frame_slave_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .sdi     (sdi),
    .rd_data (rd_data),
    .sdo     (sdo),
    .rd_stb  (rd_stb),
    .wr_stb  (wr_stb),
    .rd_addr (rd_addr),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  register_bank register_bank_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_addr     (rd_addr),
    .wr_addr     (wr_addr),
    .wr_stb      (wr_stb),
    .wr_data     (wr_data),
    .rd_data     (rd_data),
    .reg_led     (reg_led),
    .reg_spi_mux (reg_spi_mux),
    .reg_4094    (reg_4094),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct),
    .reg_direct2 (reg_direct2),
    .load_4094   (load_4094)
  );

  hc4094_driver hc4094_driver_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_4094 (load_4094),
    .reg_4094  (reg_4094),   // also a top level output
    .sr_clk    (sr_clk),
    .sr_data   (sr_data),
    .sr_strobe (sr_strobe)
  );

endmodule

`default_nettype wire

// ==== tests/spi_ctl_checker.sv ====
/* spi control checker
   decodes frames from the pins, keeps a register model, compares dut outputs */

`timescale 1ns/1ns
`default_nettype none

`include "regs_consts.svh"

module spi_ctl_checker import regs_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      sclk,
  input  wire logic      cs_n,
  input  wire logic      sdi,
  input  wire logic      sdo,
  input  wire reg_word_t reg_led,
  input  wire reg_word_t reg_spi_mux,
  input  wire reg_word_t reg_4094,
  input  wire reg_word_t reg_mode,
  input  wire reg_word_t reg_direct,
  input  wire reg_word_t reg_direct2,
  input  wire logic      sr_clk,
  input  wire logic      sr_data,
  input  wire logic      sr_strobe,
  output int             tests_run,
  output int             tests_failed,
  output int             error_count,
  output logic           chain_idle     // last reg 9 write has been latched
);

  reg_word_t              model [0:127];   // by address, unmapped entries unused
  logic [`FRAME_BITS-1:0] frame_bits;
  reg_word_t              sdo_word;        // read data seen on rising sclk
  reg_word_t              exp_rd;
  reg_word_t              chain_cap;       // last 32 bits on rising sr_clk
  int                     fall_cnt;
  int                     test_errs;
  logic                   reset_checked;
  logic                   prev_sclk;
  logic                   prev_cs_n;
  logic                   prev_sdi;
  logic                   prev_sr_clk;

  function automatic logic is_mapped(input reg_addr_t addr);
    case (addr)
      `REG_LED, `REG_SPI_MUX, `REG_4094, `REG_MODE, `REG_DIRECT, `REG_DIRECT2:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  // what a read of addr should shift out
  function automatic reg_word_t expected_read(input reg_addr_t addr);
    return is_mapped(addr) ? model[addr] : `UNKNOWN_PATTERN;
  endfunction

  task automatic compare_word(input string name, input reg_word_t act, input reg_word_t exp);
    if (act !== exp)
    begin
      $display("error: %s = 0x%08h, expected 0x%08h", name, act, exp);
      error_count++;
      test_errs++;
    end
  endtask

  task automatic compare_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
      $display("error: %s = 0x%0h, expected 0x%0h", name, act, exp);
      error_count++;
      test_errs++;
    end
  endtask

  // all six outputs at once, so a write that hits the wrong register shows up
  task automatic check_registers();
    compare_word("reg_led", reg_led, model[`REG_LED]);
    compare_word("reg_spi_mux", reg_spi_mux, model[`REG_SPI_MUX]);
    compare_word("reg_4094", reg_4094, model[`REG_4094]);
    compare_word("reg_mode", reg_mode, model[`REG_MODE]);
    compare_word("reg_direct", reg_direct, model[`REG_DIRECT]);
    compare_word("reg_direct2", reg_direct2, model[`REG_DIRECT2]);
  endtask

  task automatic finish_test(input string what);
    tests_run++;
    if (test_errs != 0)
      tests_failed++;
    $display("test %0d: %s %s", tests_run, what, (test_errs == 0) ? "ok" : "FAILED");
    test_errs = 0;
  endtask

  // pins are driven on falling clk, so everything is stable here
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      model = '{default: '0};
      model[`REG_LED] = `LED_RESET;
      frame_bits    = '0;
      sdo_word      = '0;
      exp_rd        = '0;
      chain_cap     = '0;
      fall_cnt      = 0;
      test_errs     = 0;
      tests_run     = 0;
      tests_failed  = 0;
      error_count   = 0;
      chain_idle    = 1'b1;
      reset_checked = 1'b0;
      prev_sclk     = 1'b1;   // sclk idles high
      prev_cs_n     = 1'b1;
      prev_sdi      = 1'b0;
      prev_sr_clk   = 1'b0;
    end
    else
    begin
      if (!reset_checked)
      begin
        check_registers();
        compare_bit("sdo", sdo, 1'b0);
        compare_bit("sr_clk", sr_clk, 1'b0);
        compare_bit("sr_strobe", sr_strobe, 1'b0);
        finish_test("reset values");
        reset_checked = 1'b1;
      end
      if (!cs_n && prev_cs_n)
      begin
        fall_cnt   = 0;   // new frame
        frame_bits = '0;
        sdo_word   = '0;
      end
      if (!cs_n && prev_sclk && !sclk)
      begin
        frame_bits = {frame_bits[`FRAME_BITS-2:0], prev_sdi};   // bit held before the fall
        fall_cnt++;
        if (fall_cnt == 8)
          exp_rd = expected_read(frame_bits[6:0]);
        if (fall_cnt == `FRAME_BITS && !frame_bits[39])
        begin
          if (is_mapped(frame_bits[38:32]))
            model[frame_bits[38:32]] = frame_bits[31:0];
          if (frame_bits[38:32] == `REG_4094)
            chain_idle = 1'b0;   // a chain update is now owed
        end
      end
      if (!cs_n && !prev_sclk && sclk && fall_cnt >= 8 && fall_cnt < `FRAME_BITS)
        sdo_word = {sdo_word[30:0], sdo};   // master samples on the rise
      if (cs_n && !prev_cs_n)
      begin
        check_registers();
        if (fall_cnt == `FRAME_BITS)
        begin
          compare_word("sdo", sdo_word, exp_rd);
          finish_test($sformatf("%s addr 0x%02h data 0x%08h",
                                frame_bits[39] ? "read " : "write",
                                frame_bits[38:32], frame_bits[31:0]));
        end
        else
          finish_test($sformatf("frame aborted after %0d bits", fall_cnt));
      end
      if (sr_clk && !prev_sr_clk)
        chain_cap = {chain_cap[30:0], sr_data};
      if (sr_strobe)
      begin
        compare_word("4094 chain", chain_cap, model[`REG_4094]);
        chain_idle = 1'b1;
        finish_test($sformatf("4094 chain latched 0x%08h", chain_cap));
      end
      prev_sclk   = sclk;
      prev_cs_n   = cs_n;
      prev_sdi    = sdi;
      prev_sr_clk = sr_clk;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_spi_ctl.sv ====
/* testbench for the spi control block
   spi master runs frames from a pattern file, spi_ctl_checker compares */

`timescale 1ns/1ns
`default_nettype none

`include "regs_consts.svh"

module tb_spi_ctl import regs_pkg::*; ();

  localparam int SCLK_HALF    = 5;    // clk cycles per sclk phase
  localparam int FRAME_GAP    = 10;   // cs_n high between frames
  localparam int RESET_CYCLES = 16;

  logic      clk;
  logic      rst_n;
  logic      sclk;
  logic      cs_n;
  logic      sdi;
  logic      sdo;
  reg_word_t reg_led;
  reg_word_t reg_spi_mux;
  reg_word_t reg_4094;
  reg_word_t reg_mode;
  reg_word_t reg_direct;
  reg_word_t reg_direct2;
  logic      sr_clk;
  logic      sr_data;
  logic      sr_strobe;
  int        tests_run;
  int        tests_failed;
  int        error_count;
  logic      chain_idle;

  // one entry per pattern line
  logic      pat_rd [$];
  reg_addr_t pat_addr [$];
  reg_word_t pat_data [$];
  int        pat_bits [$];
  int        seed = 32'h3ca4_361a;
  int        wd_cycles = 0;
  logic      run_ok;

  spi_ctl_top spi_ctl_top_inst (
    .clk (clk), .rst_n (rst_n), .sclk (sclk), .cs_n (cs_n), .sdi (sdi), .sdo (sdo),
    .reg_led (reg_led), .reg_spi_mux (reg_spi_mux), .reg_4094 (reg_4094),
    .reg_mode (reg_mode), .reg_direct (reg_direct), .reg_direct2 (reg_direct2),
    .sr_clk (sr_clk), .sr_data (sr_data), .sr_strobe (sr_strobe)
  );

  spi_ctl_checker spi_ctl_checker_inst (
    .clk (clk), .rst_n (rst_n), .sclk (sclk), .cs_n (cs_n), .sdi (sdi), .sdo (sdo),
    .reg_led (reg_led), .reg_spi_mux (reg_spi_mux), .reg_4094 (reg_4094),
    .reg_mode (reg_mode), .reg_direct (reg_direct), .reg_direct2 (reg_direct2),
    .sr_clk (sr_clk), .sr_data (sr_data), .sr_strobe (sr_strobe),
    .tests_run (tests_run), .tests_failed (tests_failed), .error_count (error_count),
    .chain_idle (chain_idle)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic load_patterns(output logic ok);
    int        fd;
    int        n;
    int        nbits;
    string     line;
    string     op;
    string     dtok;
    reg_addr_t addr;
    reg_word_t data;
    ok = 1'b1;
    fd = $fopen("tests/spi_ctl_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the pattern file tests/spi_ctl_patterns.txt");
      ok = 1'b0;
      return;
    end
    while (!$feof(fd))
    begin
      if ($fgets(line, fd) == 0)
        break;
      if (line.len() == 0 || line.getc(0) == "#")
        continue;   // column notes
      n = $sscanf(line, "%s %h %s %d", op, addr, dtok, nbits);
      if (n != 4)
        continue;
      if (op != "r" && op != "w")
      begin
        $display("unknown opcode %s in the pattern file", op);
        ok = 1'b0;
      end
      if (dtok == "rand")
        data = $random(seed);
      else
      begin
        n = $sscanf(dtok, "%h", data);
        if (n != 1)
        begin
          $display("bad data field %s in the pattern file", dtok);
          ok = 1'b0;
        end
      end
      pat_rd.push_back(op == "r");
      pat_addr.push_back(addr);
      pat_data.push_back(data);
      pat_bits.push_back((nbits == 0) ? `FRAME_BITS : nbits);
    end
    $fclose(fd);
  endtask

  // sclk idles high, the first bit is set up before the first fall
  task automatic send_frame(input logic rd, input reg_addr_t addr, input reg_word_t data,
                            input int nbits);
    logic [`FRAME_BITS-1:0] frame;
    frame = {rd, addr, data};
    cs_n  = 1'b0;
    sdi   = frame[`FRAME_BITS-1];
    repeat (SCLK_HALF) @(negedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      frame = frame << 1;
      sclk  = 1'b0;
      sdi   = frame[`FRAME_BITS-1];   // next bit changes with the fall
      repeat (SCLK_HALF) @(negedge clk);
      sclk  = 1'b1;
      repeat (SCLK_HALF) @(negedge clk);
    end
    cs_n = 1'b1;   // early rise when nbits is short
    sdi  = 1'b0;
    repeat (FRAME_GAP) @(negedge clk);
  endtask

  initial
  begin
    int n_w9;
    rst_n = 1'b0;
    sclk  = 1'b1;
    cs_n  = 1'b1;
    sdi   = 1'b0;
    n_w9  = 0;
    load_patterns(run_ok);
    foreach (pat_addr[i])
      if (!pat_rd[i] && pat_addr[i] == `REG_4094)
        n_w9++;
    // frames plus one 4094 update per reg 9 write, with room to spare
    wd_cycles = RESET_CYCLES + 100
                + pat_addr.size() * (`FRAME_BITS * 2 * SCLK_HALF + 200) + n_w9 * 2 * 129;
    if (run_ok)
    begin
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      repeat (4) @(negedge clk);
      foreach (pat_addr[i])
        send_frame(pat_rd[i], pat_addr[i], pat_data[i], pat_bits[i]);
      while (chain_idle !== 1'b1)   // last reg 9 value still shifting out
        @(negedge clk);
      repeat (2) @(negedge clk);
      if (tests_run < pat_addr.size() + 1)
      begin
        $display("only %0d tests were checked, at least %0d expected",
                 tests_run, pat_addr.size() + 1);
        run_ok = 1'b0;
      end
    end
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (run_ok && tests_failed == 0 && error_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // watchdog, limit set once the pattern file is loaded
  initial
  begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("timeout, the run did not finish within %0d clk cycles", wd_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
design/regs_pkg.sv
design/spi_frame_slave.sv
design/register_bank.sv
design/hc4094_driver.sv
design/spi_ctl_top.sv
tests/spi_ctl_checker.sv
tests/tb_spi_ctl.sv

// ==== Makefile ====
# Verilator build and run of the spi control block testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_spi_ctl
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides the result, the binary exits 0 either way
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/spi_ctl_patterns.txt ====
# columns op addr data bits, op r reads and w writes, addr and data in hex
# data rand draws from $random, bits 0 sends all 40 bits, else cs_n rises after that many
r 07 00000000 0
r 08 00000000 0
r 09 00000000 0
r 0c 00000000 0
r 0e 00000000 0
r 0f 00000000 0
w 07 12345678 0
r 07 00000000 0
w 08 rand 0
r 08 00000000 0
w 09 deadbeef 0
r 09 00000000 0
w 0c rand 0
r 0c 00000000 0
w 0e 0f0f00ff 0
r 0e 00000000 0
w 0f rand 0
r 0f 00000000 0
r 05 00000000 0
r 7f ffffffff 0
w 05 11111111 0
w 0a 22222222 0
w 07 cafef00d 20
w 09 87654321 39
w 08 55555555 5
r 07 ffffffff 0
r 09 a5a5a5a5 0
w 09 13579bdf 0
w 09 rand 0
r 09 00000000 0
